// File: e100_consts.svh
// 100G status subsystem constants
`ifndef E100_CONSTS_SVH
`define E100_CONSTS_SVH

// stream geometry
`define E100_WORDS       4            // words per stream beat
`define E100_WIDTH       64           // bits per payload word

// status bus geometry
`define E100_ADDR_W      16
`define E100_DATA_W      32

// register windows, 256 addresses each, picked by addr[15:8]
`define E100_PC_BASE     16'h0100     // packet client
`define E100_CFP_BASE    16'h0200     // optics controller

// returned for reads nobody claims
`define E100_UNMAPPED    32'hDEADC0DE

// combiner gives up after this many cycles
`define E100_RD_TIMEOUT  4

// burst limits, as field widths of the control word
`define E100_PKTS_W      8            // up to 255 packets per burst
`define E100_BEATS_W     4            // 1 to 15 beats per packet

`endif

// File: e100_bus_pkg.sv
// status bus types
`default_nettype none
`include "e100_consts.svh"

package e100_bus_pkg;

    ////////////////////////////////////////////////////////////////////
    // plain vectors
    ////////////////////////////////////////////////////////////////////

    typedef logic [`E100_ADDR_W-1:0] stat_addr_t;   // register address
    typedef logic [`E100_DATA_W-1:0] stat_data_t;   // register data

    ////////////////////////////////////////////////////////////////////
    // host to client
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        stat_addr_t addr;
        logic       read;       // single cycle strobe
        logic       write;      // single cycle strobe
        stat_data_t writedata;
    } stat_req_t;

    // client to host, valid one cycle per answered read
    typedef struct packed {
        stat_data_t readdata;
        logic       readdata_valid;
    } stat_rsp_t;

endpackage

`default_nettype wire

// File: e100_pkt_pkg.sv
// packet stream types
`default_nettype none
`include "e100_consts.svh"

package e100_pkt_pkg;

    typedef logic [`E100_WIDTH-1:0] pay_word_t;     // one payload word

    ////////////////////////////////////////////////////////////////////
    // one beat of the wide stream, word 0 goes first
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        pay_word_t [`E100_WORDS-1:0]   data;
        logic      [`E100_WORDS-1:0]   start;       // bit 0 on first beat
        logic      [`E100_WORDS*8-1:0] end_pos;     // one-hot last byte
    } stream_beat_t;

    // transmit sequencer
    typedef enum logic [1:0] {
        pc_idle = 2'd0,     // waiting for a start write
        pc_send = 2'd1,     // driving beats
        pc_gap  = 2'd2      // one dead cycle after each packet
    } pc_state_t;

endpackage

`default_nettype wire

// File: e100_packet_client.sv
// burst generator and loopback checker
`timescale 1ns/1ps
`default_nettype none
`include "e100_consts.svh"

module e100_packet_client (
    input  wire                          clk,
    input  wire                          rst,
    input  wire e100_bus_pkg::stat_req_t req,
    output e100_bus_pkg::stat_rsp_t      rsp,
    output e100_pkt_pkg::stream_beat_t   tx,
    output logic                         tx_valid,
    input  wire                          tx_ack,
    input  wire e100_pkt_pkg::stream_beat_t rx,
    input  wire                          rx_valid
);

    localparam int WORDS = `E100_WORDS;
    localparam logic [7:0] WIN = 8'(`E100_PC_BASE >> 8);
    localparam logic [WORDS*8-1:0] END_MARK = 1 << ((WORDS - 1) * 8); // byte 0, last word

    e100_pkt_pkg::pc_state_t   state;
    logic [`E100_PKTS_W-1:0]   pkt_total, pkt_cnt;
    logic [`E100_BEATS_W-1:0]  beats_per, beat_cnt, rx_beat;
    e100_pkt_pkg::pay_word_t   word_cnt, rx_exp;
    e100_bus_pkg::stat_data_t  sent_cnt, good_cnt, bad_cnt, rd_data;
    logic sel, ctrl_wr, start_burst, clr_cnt, rd_valid;
    logic tx_fire, tx_last_beat;
    logic rx_err, rx_last, rx_end, rx_words_ok, rx_start_ok, rx_end_ok, rx_bad;

    assign sel         = req.addr[15:8] == WIN;
    assign ctrl_wr     = sel && req.write && req.addr[7:0] == 8'h00;
    assign start_burst = ctrl_wr && req.writedata[31] && state == e100_pkt_pkg::pc_idle;
    assign clr_cnt     = ctrl_wr && req.writedata[30];

    //////////////////////////////////////////////////////////////////////
    // transmit
    //////////////////////////////////////////////////////////////////////

    assign tx_valid     = state == e100_pkt_pkg::pc_send;
    assign tx_fire      = tx_valid && tx_ack;
    assign tx_last_beat = beat_cnt == beats_per - 1'b1;

    // beat comes straight from registers, so it holds while ack is low
    always_comb begin
        tx = '0;
        for (int i = 0; i < WORDS; i++) begin
            tx.data[i] = word_cnt + e100_pkt_pkg::pay_word_t'(i);
        end
        tx.start   = WORDS'(beat_cnt == '0);    // word 0 of first beat
        tx.end_pos = tx_last_beat ? END_MARK : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= e100_pkt_pkg::pc_idle;
            pkt_total <= '0;
            pkt_cnt   <= '0;
            beats_per <= `E100_BEATS_W'(1);
            beat_cnt  <= '0;
            word_cnt  <= '0;
        end else begin
            case (state)
                e100_pkt_pkg::pc_idle: if (start_burst) begin
                    pkt_total <= req.writedata[7:0];
                    beats_per <= (req.writedata[11:8] == '0) ? `E100_BEATS_W'(1) :
                                 req.writedata[11:8];   // zero beats means one
                    pkt_cnt   <= '0;
                    beat_cnt  <= '0;
                    word_cnt  <= '0;                    // sequence restarts per burst
                    if (req.writedata[7:0] != '0)
                        state <= e100_pkt_pkg::pc_send;
                end
                e100_pkt_pkg::pc_send: if (tx_fire) begin
                    word_cnt <= word_cnt + e100_pkt_pkg::pay_word_t'(WORDS);
                    if (tx_last_beat) begin
                        beat_cnt <= '0;
                        pkt_cnt  <= pkt_cnt + 1'b1;
                        state    <= e100_pkt_pkg::pc_gap;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                e100_pkt_pkg::pc_gap:   // gap done, more to send?
                    state <= (pkt_cnt == pkt_total) ? e100_pkt_pkg::pc_idle :
                                                      e100_pkt_pkg::pc_send;
                default: state <= e100_pkt_pkg::pc_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // receive check
    //////////////////////////////////////////////////////////////////////

    assign rx_last = rx_beat == beats_per - 1'b1;
    assign rx_end  = (|rx.end_pos) || rx_last;      // close on either marker

    always_comb begin
        rx_words_ok = 1'b1;
        for (int i = 0; i < WORDS; i++) begin
            if (rx.data[i] != rx_exp + e100_pkt_pkg::pay_word_t'(i))
                rx_words_ok = 1'b0;
        end
    end

    assign rx_start_ok = rx.start == WORDS'(rx_beat == '0);
    assign rx_end_ok   = rx.end_pos == (rx_last ? END_MARK : '0);
    assign rx_bad      = rx_err || !rx_words_ok || !rx_start_ok || !rx_end_ok;

    always_ff @(posedge clk) begin
        if (rst || start_burst) begin
            rx_exp  <= '0;
            rx_beat <= '0;
            rx_err  <= 1'b0;
        end else if (rx_valid) begin
            rx_exp <= rx_exp + e100_pkt_pkg::pay_word_t'(WORDS); // stays in step after a bad word
            if (rx_end) begin
                rx_beat <= '0;
                rx_err  <= 1'b0;
            end else begin
                rx_beat <= rx_beat + 1'b1;
                rx_err  <= rx_bad;              // carry fault to end of packet
            end
        end
    end

    // packet counters
    always_ff @(posedge clk) begin
        if (rst || clr_cnt) begin
            sent_cnt <= '0;
            good_cnt <= '0;
            bad_cnt  <= '0;
        end else begin
            if (tx_fire && tx_last_beat)
                sent_cnt <= sent_cnt + 1'b1;
            if (rx_valid && rx_end) begin
                if (rx_bad)
                    bad_cnt  <= bad_cnt + 1'b1;
                else
                    good_cnt <= good_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // status reads, one cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= sel && req.read;
    end

    always_ff @(posedge clk) begin
        case (req.addr[7:0])
            8'h04:   rd_data <= sent_cnt;
            8'h08:   rd_data <= good_cnt;
            8'h0C:   rd_data <= bad_cnt;
            8'h10:   rd_data <= e100_bus_pkg::stat_data_t'(state != e100_pkt_pkg::pc_idle);
            default: rd_data <= '0;             // control is write only
        endcase
    end

    assign rsp = '{readdata: rd_data, readdata_valid: rd_valid};

endmodule

`default_nettype wire

// File: e100_optics_control.sv
// CFP pin control and alarm latch
`timescale 1ns/1ps
`default_nettype none
`include "e100_consts.svh"

module e100_optics_control (
    input  wire                          clk,
    input  wire                          rst,
    input  wire e100_bus_pkg::stat_req_t req,
    output e100_bus_pkg::stat_rsp_t      rsp,
    input  wire                          cfp_glb_alrm,
    input  wire                          cfp_mod_abs,
    input  wire                          cfp_rx_los,
    input  wire [3:1]                    cfp_prg_alrm,
    output logic                         cfp_mod_lopwr,
    output logic                         cfp_mod_rst,   // active low
    output logic                         cfp_tx_dis,
    output logic [4:0]                   cfp_prtadr,
    output logic [3:1]                   cfp_prg_cntl
);

    localparam logic [7:0] WIN = 8'(`E100_CFP_BASE >> 8);

    logic [10:0] ctrl;              // pin control, read-write
    logic [5:0]  alarm, alarm_pin;  // sticky latches and their sources
    logic        sel, rd_valid;
    e100_bus_pkg::stat_data_t rd_data;

    assign sel       = req.addr[15:8] == WIN;
    assign alarm_pin = {cfp_prg_alrm, cfp_rx_los, cfp_mod_abs, cfp_glb_alrm};

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl  <= 11'h002;                   // module out of reset
            alarm <= '0;
        end else begin
            if (sel && req.write && req.addr[7:0] == 8'h00)
                ctrl <= req.writedata[10:0];
            // pin set wins over a clear in the same cycle
            if (sel && req.write && req.addr[7:0] == 8'h04)
                alarm <= (alarm & ~req.writedata[5:0]) | alarm_pin;
            else
                alarm <= alarm | alarm_pin;
        end
    end

    assign cfp_mod_lopwr = ctrl[0];
    assign cfp_mod_rst   = ctrl[1];
    assign cfp_tx_dis    = ctrl[2];
    assign cfp_prtadr    = ctrl[7:3];
    assign cfp_prg_cntl  = ctrl[10:8];

    // read return, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= sel && req.read;
    end

    always_ff @(posedge clk) begin
        case (req.addr[7:0])
            8'h00:   rd_data <= e100_bus_pkg::stat_data_t'(ctrl);
            8'h04:   rd_data <= e100_bus_pkg::stat_data_t'(alarm);
            default: rd_data <= '0;
        endcase
    end

    assign rsp = '{readdata: rd_data, readdata_valid: rd_valid};

endmodule

`default_nettype wire

// File: e100_read_combine.sv
// status read return combiner
`timescale 1ns/1ps
`default_nettype none
`include "e100_consts.svh"

module e100_read_combine (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                host_read,
    input  wire e100_bus_pkg::stat_rsp_t [1:0] client_rsp,
    output e100_bus_pkg::stat_rsp_t            host_rsp,
    output logic                               host_waitrequest
);

    localparam int NUM_CLIENTS = 2;
    localparam int TO = `E100_RD_TIMEOUT;
    localparam int CW = $clog2(TO) + 1;

    e100_bus_pkg::stat_data_t merged, rsp_data;
    logic          any_valid, timeout, pending, rsp_valid;
    logic [CW-1:0] wait_cnt;    // cycles spent on the open read

    // clients stay quiet unless valid, still masked here
    always_comb begin
        merged    = '0;
        any_valid = 1'b0;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            merged    |= client_rsp[i].readdata &
                         {$bits(e100_bus_pkg::stat_data_t){client_rsp[i].readdata_valid}};
            any_valid |= client_rsp[i].readdata_valid;
        end
    end

    assign timeout = pending && !any_valid && wait_cnt == CW'(TO - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            wait_cnt  <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= any_valid || timeout;
            if (host_read) begin
                pending  <= 1'b1;
                wait_cnt <= '0;
            end else if (any_valid || timeout) begin
                pending  <= 1'b0;               // drops as valid goes out
            end else if (pending) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any_valid || timeout)
            rsp_data <= any_valid ? merged : `E100_UNMAPPED;
    end

    assign host_waitrequest = pending;
    assign host_rsp = '{readdata: rsp_data, readdata_valid: rsp_valid};

endmodule

`default_nettype wire

// File: e100_status_top.sv
// 100G status subsystem top
`timescale 1ns/1ps
`default_nettype none

module e100_status_top (
    input  wire                             clk,
    input  wire                             rst,
    // host status bus
    input  wire e100_bus_pkg::stat_req_t    req,
    output e100_bus_pkg::stat_rsp_t         rsp,
    output logic                            waitrequest,
    // packet stream out and back in
    output e100_pkt_pkg::stream_beat_t      tx,
    output logic                            tx_valid,
    input  wire                             tx_ack,
    input  wire e100_pkt_pkg::stream_beat_t rx,
    input  wire                             rx_valid,
    // CFP pins
    input  wire                             cfp_glb_alrm,
    input  wire                             cfp_mod_abs,
    input  wire                             cfp_rx_los,
    input  wire [3:1]                       cfp_prg_alrm,
    output logic                            cfp_mod_lopwr,
    output logic                            cfp_mod_rst,    // active low
    output logic                            cfp_tx_dis,
    output logic [4:0]                      cfp_prtadr,
    output logic [3:1]                      cfp_prg_cntl
);

    e100_bus_pkg::stat_rsp_t [1:0] cli_rsp;     // 0 packet client, 1 optics

    //////////////////////////////////////////////////////////////////////
    // clients
    //////////////////////////////////////////////////////////////////////

    e100_packet_client pc (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rsp      (cli_rsp[0]),
        .tx       (tx),
        .tx_valid (tx_valid),
        .tx_ack   (tx_ack),
        .rx       (rx),
        .rx_valid (rx_valid)
    );

    e100_optics_control cc (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .rsp           (cli_rsp[1]),
        .cfp_glb_alrm  (cfp_glb_alrm),
        .cfp_mod_abs   (cfp_mod_abs),
        .cfp_rx_los    (cfp_rx_los),
        .cfp_prg_alrm  (cfp_prg_alrm),
        .cfp_mod_lopwr (cfp_mod_lopwr),
        .cfp_mod_rst   (cfp_mod_rst),
        .cfp_tx_dis    (cfp_tx_dis),
        .cfp_prtadr    (cfp_prtadr),
        .cfp_prg_cntl  (cfp_prg_cntl)
    );

    // merge read returns for the host
    e100_read_combine arc (
        .clk              (clk),
        .rst              (rst),
        .host_read        (req.read),
        .client_rsp       (cli_rsp),
        .host_rsp         (rsp),
        .host_waitrequest (waitrequest)
    );

endmodule

`default_nettype wire

// File: e100_status_assert.sv
// status bus and stream assertions
`timescale 1ns/1ps
`default_nettype none

module e100_status_assert (
    input wire                             clk,
    input wire                             rst,
    input wire                             read,         // host read strobe
    input wire                             rsp_valid,    // host readdata_valid
    input wire                             waitrequest,
    input wire e100_pkt_pkg::stream_beat_t tx,
    input wire                             tx_valid,
    input wire                             tx_ack,
    input wire e100_pkt_pkg::pc_state_t    state        // packet client sequencer
);

    //////////////////////////////////////////////////////////////////////
    // status bus
    //////////////////////////////////////////////////////////////////////

    // mapped reads answer after 2 cycles, unmapped after 5
    read_latency: assert property (@(posedge clk) disable iff (rst)
        read |-> (##2 rsp_valid) or (##5 rsp_valid))
        else $error("read return not 2 or 5 cycles after the strobe");

    // low out of reset, and stays low until a read comes
    wait_after_reset: assert property (@(posedge clk)
        (rst || (!read && !waitrequest)) |=> !waitrequest)
        else $error("waitrequest high without a read after reset");

    //////////////////////////////////////////////////////////////////////
    // stream
    //////////////////////////////////////////////////////////////////////

    tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ack |=> tx_valid && $stable(tx))
        else $error("tx beat changed while stalled");

    state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {e100_pkt_pkg::pc_idle, e100_pkt_pkg::pc_send, e100_pkt_pkg::pc_gap})
        else $error("packet client state out of range");

endmodule

// attach to every status top
bind e100_status_top e100_status_assert status_assert_inst (
    .clk         (clk),
    .rst         (rst),
    .read        (req.read),
    .rsp_valid   (rsp.readdata_valid),
    .waitrequest (waitrequest),
    .tx          (tx),
    .tx_valid    (tx_valid),
    .tx_ack      (tx_ack),
    .state       (pc.state)
);

`default_nettype wire

// File: e100_status_checker.sv
// status read checker
`timescale 1ns/1ps
`default_nettype none
`include "e100_consts.svh"

module e100_status_checker (
    input wire                             clk,
    input wire e100_bus_pkg::stat_req_t    req,         // host request, for burst starts
    input wire e100_bus_pkg::stat_rsp_t    rsp,         // host read return
    input wire                             waitrequest,
    input wire e100_pkt_pkg::stream_beat_t tx,
    input wire                             tx_valid,
    input wire                             tx_ack,
    input wire [10:0]                      pins         // cfp outputs in control register order
);

    localparam int RSP_LIMIT = 8;   // longest legal answer is 5 cycles

    int ok_cnt   = 0;
    int fail_cnt = 0;

    // transmit stream model
    int unsigned next_word = 0;     // payload index k in the burst
    int          beats_per = 1;
    int          beat_idx  = 0;     // beat within the packet
    int          beat_cnt  = 0;     // accepted beats seen
    int          beat_fail = 0;

    //////////////////////////////////////////////////////////////////////
    // compare tasks, called by the testbench after each request
    //////////////////////////////////////////////////////////////////////

    // wait for the host read return, sampled on the edge after it rises
    task automatic expect_read(input string name, input e100_bus_pkg::stat_data_t exp);
        int   waited;
        logic wait_seen;            // waitrequest in the cycle after the strobe
        waited = 0;
        @(posedge clk);
        waited++;
        wait_seen = waitrequest;
        while (rsp.readdata_valid !== 1'b1 && waited < RSP_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (rsp.readdata_valid !== 1'b1) begin
            $display("%s missing read response after %0d cycles", name, waited);
            fail_cnt++;
        end else if (rsp.readdata !== exp) begin
            $display("ERR %s expected 0x%08h actual 0x%08h", name, exp, rsp.readdata);
            fail_cnt++;
        end else if (wait_seen !== 1'b1 || waitrequest !== 1'b0) begin
            $display("ERR %s waitrequest expected 1,0 actual %b,%b",
                     name, wait_seen, waitrequest);
            fail_cnt++;
        end else begin
            $display("ok  %s read 0x%08h", name, rsp.readdata);
            ok_cnt++;
        end
    endtask

    // pins follow the control register with no delay
    task automatic expect_pins(input string name, input logic [10:0] exp);
        @(posedge clk);
        if (pins !== exp) begin
            $display("ERR %s expected 0x%03h actual 0x%03h", name, exp, pins);
            fail_cnt++;
        end else begin
            $display("ok  %s pins 0x%03h", name, pins);
            ok_cnt++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // transmit stream against the burst rules
    //////////////////////////////////////////////////////////////////////

    // word k carries k, start on word 0 of the first beat, end at byte 0 of the last word
    task automatic check_beat();
        e100_pkt_pkg::stream_beat_t want;
        want = '0;
        for (int i = 0; i < `E100_WORDS; i++)
            want.data[i] = e100_pkt_pkg::pay_word_t'(next_word + i);
        want.start[0] = beat_idx == 0;
        if (beat_idx == beats_per - 1)
            want.end_pos[(`E100_WORDS - 1) * 8] = 1'b1;
        if (tx !== want) begin
            $display("ERR tx_stream beat %0d expected 0x%h actual 0x%h", beat_cnt, want, tx);
            beat_fail++;
        end
        beat_cnt++;
        next_word += `E100_WORDS;
        beat_idx = (beat_idx == beats_per - 1) ? 0 : beat_idx + 1;
    endtask

    always @(posedge clk) begin
        if (req.write && req.addr == `E100_PC_BASE && req.writedata[31]) begin
            next_word = 0;                          // sequence restarts per burst
            beats_per = int'(req.writedata[11:8]);
            beat_idx  = 0;
        end else if (tx_valid && tx_ack) begin
            check_beat();
        end
    end

    task automatic report();
        if (beat_cnt == 0) begin
            $display("tx_stream saw no accepted beats");
            fail_cnt++;
        end else if (beat_fail != 0) begin
            $display("tx_stream %0d of %0d beats wrong", beat_fail, beat_cnt);
            fail_cnt++;
        end else begin
            $display("ok  tx_stream %0d beats", beat_cnt);
            ok_cnt++;
        end
        $display("checks %0d run, %0d ok, %0d failed", ok_cnt + fail_cnt, ok_cnt, fail_cnt);
    endtask

endmodule

`default_nettype wire

// File: tb_e100_status_top.sv
// 100G status subsystem testbench
`timescale 1ns/1ps
`default_nettype none
`include "e100_consts.svh"

module tb_e100_status_top;

    logic                       clk;
    logic                       rst;
    e100_bus_pkg::stat_req_t    req;
    e100_bus_pkg::stat_rsp_t    rsp;
    logic                       waitrequest;
    e100_pkt_pkg::stream_beat_t tx, rx, looped;
    logic                       tx_valid, tx_ack, rx_valid;
    logic                       cfp_glb_alrm, cfp_mod_abs, cfp_rx_los;
    logic [3:1]                 cfp_prg_alrm, cfp_prg_cntl;
    logic                       cfp_mod_lopwr, cfp_mod_rst, cfp_tx_dis;
    logic [4:0]                 cfp_prtadr;

    integer                  seed = 22;     // tx_ack stream
    e100_pkt_pkg::pay_word_t flip_mask;
    int                      flip_req = 0;  // corruption requests from the op list
    int                      flip_done = 0; // corruptions applied by the loopback
    int                      limit_cycles = 0;
    int                      cycle_cnt = 0;
    logic                    setup_err = 1'b0;

    // operations from the data file
    string                    op_name[$];
    logic [7:0]               op_code[$];
    e100_bus_pkg::stat_addr_t op_addr[$];
    e100_bus_pkg::stat_data_t op_data[$];
    e100_bus_pkg::stat_data_t op_exp[$];

    e100_status_top e100_status_top_inst (
        .clk(clk), .rst(rst), .req(req), .rsp(rsp), .waitrequest(waitrequest),
        .tx(tx), .tx_valid(tx_valid), .tx_ack(tx_ack), .rx(rx), .rx_valid(rx_valid),
        .cfp_glb_alrm(cfp_glb_alrm), .cfp_mod_abs(cfp_mod_abs), .cfp_rx_los(cfp_rx_los),
        .cfp_prg_alrm(cfp_prg_alrm), .cfp_mod_lopwr(cfp_mod_lopwr),
        .cfp_mod_rst(cfp_mod_rst), .cfp_tx_dis(cfp_tx_dis),
        .cfp_prtadr(cfp_prtadr), .cfp_prg_cntl(cfp_prg_cntl)
    );

    e100_status_checker chk (
        .clk         (clk),
        .req         (req),
        .rsp         (rsp),
        .waitrequest (waitrequest),
        .tx          (tx),
        .tx_valid    (tx_valid),
        .tx_ack      (tx_ack),
        .pins        ({cfp_prg_cntl, cfp_prtadr, cfp_tx_dis, cfp_mod_rst, cfp_mod_lopwr})
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // stream loopback with back-pressure
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        tx_ack <= ($random(seed) % 4) != 0;     // high about 3 cycles in 4
        looped = tx;
        if (tx_valid && tx_ack && flip_req != flip_done) begin
            looped.data[0] = looped.data[0] ^ flip_mask;
            flip_done <= flip_done + 1;
        end
        rx       <= looped;
        rx_valid <= tx_valid && tx_ack && !rst;  // only beats that were taken
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (limit_cycles > 0 && cycle_cnt >= limit_cycles) begin
            $display("timeout, run did not finish within %0d cycles", limit_cycles);
            $display("test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tasks
    //////////////////////////////////////////////////////////////////////

    // read every op line, 20 cycles each plus 40 per requested beat
    task automatic load_ops();
        int               fd, n, pkts, bpp, beats;
        logic [8*160-1:0] line_v;
        logic [8*32-1:0]  name_v;
        logic [7:0]       code_v;
        logic [15:0]      addr_v;
        logic [31:0]      data_v, exp_v;
        beats = 0;
        fd = $fopen("e100_status_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open e100_status_testdata.txt");
            setup_err = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line_v = '0;
                n = $fgets(line_v, fd);
                // header lines fail the scan and drop out
                if (n != 0 && $sscanf(line_v, "%s %s %h %h %h",
                                      name_v, code_v, addr_v, data_v, exp_v) == 5) begin
                    op_name.push_back(string'(name_v));
                    op_code.push_back(code_v);
                    op_addr.push_back(addr_v);
                    op_data.push_back(data_v);
                    op_exp.push_back(exp_v);
                    if (code_v == "W" && addr_v == `E100_PC_BASE && data_v[31]) begin
                        pkts  = int'(data_v[7:0]);
                        bpp   = (data_v[11:8] == 4'd0) ? 1 : int'(data_v[11:8]);
                        beats = beats + pkts * bpp;
                    end
                end
            end
            $fclose(fd);
        end
        limit_cycles = op_name.size() * 20 + beats * 40 + 100;
    endtask

    task automatic bus_write(input e100_bus_pkg::stat_addr_t addr,
                             input e100_bus_pkg::stat_data_t data);
        @(posedge clk);
        req.addr      <= addr;
        req.write     <= 1'b1;
        req.writedata <= data;
        @(posedge clk);
        req.write     <= 1'b0;
    endtask

    // strobe only, the return is picked up by the caller
    task automatic bus_read(input e100_bus_pkg::stat_addr_t addr);
        @(posedge clk);
        req.addr <= addr;
        req.read <= 1'b1;
        @(posedge clk);
        req.read <= 1'b0;
    endtask

    // poll the busy register until the burst is over
    task automatic wait_not_busy(input e100_bus_pkg::stat_addr_t addr);
        logic busy;
        busy = 1'b1;
        while (busy) begin
            bus_read(addr);
            do begin
                @(posedge clk);
            end while (rsp.readdata_valid !== 1'b1);
            busy = rsp.readdata[0];
        end
    endtask

    task automatic run_op(input int i);
        case (op_code[i])
            "W": bus_write(op_addr[i], op_data[i]);
            "R": begin
                bus_read(op_addr[i]);
                chk.expect_read(op_name[i], op_exp[i]);
            end
            "O": chk.expect_pins(op_name[i], op_exp[i][10:0]);
            "P": begin
                @(posedge clk);
                {cfp_prg_alrm, cfp_rx_los, cfp_mod_abs, cfp_glb_alrm} <= op_data[i][5:0];
            end
            "C": begin
                @(posedge clk);
                flip_mask <= e100_pkt_pkg::pay_word_t'(op_data[i]);
                flip_req  <= flip_req + 1;      // next looped beat gets it
            end
            "B": wait_not_busy(op_addr[i]);
            default: begin
                $display("unknown opcode %c in line %s", op_code[i], op_name[i]);
                setup_err = 1'b1;
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst          = 1'b1;
        req          = '0;
        tx_ack       = 1'b0;
        rx           = '0;
        rx_valid     = 1'b0;
        cfp_glb_alrm = 1'b0;
        cfp_mod_abs  = 1'b0;
        cfp_rx_los   = 1'b0;
        cfp_prg_alrm = '0;
        flip_mask    = '0;
        load_ops();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        foreach (op_code[i])
            run_op(i);
        repeat (4) @(posedge clk);
        chk.report();
        if (!setup_err && op_code.size() > 0 && chk.fail_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: e100_status_top.f
+incdir+.
e100_bus_pkg.sv
e100_pkt_pkg.sv
e100_packet_client.sv
e100_optics_control.sv
e100_read_combine.sv
e100_status_top.sv
e100_status_assert.sv
e100_status_checker.sv
tb_e100_status_top.sv

// File: e100_status_testdata.txt
# test            op  addr  data      expected
# op W write, R read and compare, O compare CFP pins, P drive alarm pins, C flip next looped word, B poll busy
reset_cfp_ctrl    R   0200  00000000  00000002
reset_pc_busy     R   0110  00000000  00000000
cfp_ctrl_write    W   0200  000005ad  00000000
cfp_ctrl_rdback   R   0200  00000000  000005ad
cfp_pins          O   0000  00000000  000005ad
alarm_pulse       P   0000  0000002b  00000000
alarm_release     P   0000  00000000  00000000
alarm_set         R   0204  00000000  0000002b
alarm_clear_wr    W   0204  0000003f  00000000
alarm_cleared     R   0204  00000000  00000000
burst_clean       W   0100  80000305  00000000
burst_wait        B   0110  00000000  00000000
burst_sent        R   0104  00000000  00000005
burst_good        R   0108  00000000  00000005
burst_bad         R   010c  00000000  00000000
cnt_clear         W   0100  40000000  00000000
corrupt_word      C   0000  00000001  00000000
burst_corrupt     W   0100  80000304  00000000
corrupt_wait      B   0110  00000000  00000000
corrupt_sent      R   0104  00000000  00000004
corrupt_good      R   0108  00000000  00000003
corrupt_bad       R   010c  00000000  00000001
cnt_clear_again   W   0100  40000000  00000000
cleared_sent      R   0104  00000000  00000000
cleared_good      R   0108  00000000  00000000
cleared_bad       R   010c  00000000  00000000
unmapped_read     R   0300  00000000  deadc0de
